/* cw_reg_pkg.sv */
// register map of the capture board router
package cw_reg_pkg;

	// bus widths
	localparam int DATA_W    = 8;  // one register byte
	localparam int BYTECNT_W = 16; // byte counter of a multi-byte access

	// register addresses
	localparam int ADDR_TRIGSRC = 39; // trigger source mask and combine mode
	localparam int ADDR_TRIGMOD = 40; // trigger module select, front-panel drive
	localparam int ADDR_IOROUTE = 55; // target io routing, multi-byte

	// routing register layout
	// bytes 0..3 route the four target io pins
	// byte 4 was the glitch routing and reads as zero
	// byte 5 is the extra byte, bytes 6 and 7 are reserved
	localparam int GPIO_BYTES        = 4; // one byte per target io pin
	localparam int IOROUTE_EXTRA_IDX = 5; // bus byte index of the extra byte
	localparam int IOROUTE_BYTES     = 5; // bytes kept in storage
	localparam int IOROUTE_SPAN      = 8; // byte count must stay below this

	// reset values
	localparam logic [DATA_W-1:0] TRIGSRC_RST = 8'h01; // front panel A, OR combine
	localparam logic [DATA_W-1:0] TRIGMOD_RST = 8'h00; // edge trigger, no fp drive

	// storage order: gpio1..gpio4, then extra
	// gpio1 carries tx, gpio2 carries rx after reset
	localparam logic [IOROUTE_BYTES*DATA_W-1:0] IOROUTE_RST = 40'h00_0000_0201;

endpackage

/* cw_route_pkg.sv */
// bit fields inside the trigger and io routing bytes
package cw_route_pkg;

	// trigger source byte
	// [ M M R4 R3 R2 R1 FB FA ]
	localparam int TRIG_LINES       = 6; // fpa, fpb, io1..io4
	localparam int TRIGSRC_FPA      = 0;
	localparam int TRIGSRC_FPB      = 1;
	localparam int TRIGSRC_IO_LSB   = 2; // io1 at bit 2 up to io4 at bit 5
	localparam int TRIGSRC_MODE_LSB = 6; // combine mode in bits 7:6
	localparam int COMB_W           = 2;

	// combine codes, the other two give no trigger
	localparam logic [COMB_W-1:0] COMB_OR  = 2'd0;
	localparam logic [COMB_W-1:0] COMB_AND = 2'd1;

	// trigger module byte
	// [ X X X FB FA M M M ]
	localparam int TRIGMOD_SEL_W = 3;
	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_EDGE  = 3'd0; // combined ext trigger
	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_ADVIO = 3'd1; // advanced io pattern
	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_ANA   = 3'd2; // analog pattern match
	localparam int TRIGMOD_FPA_OE = 3; // drive trigger out on front panel A
	localparam int TRIGMOD_FPB_OE = 4; // same for front panel B

	// gpio routing byte
	// [ LVLEN LVL TXOC USOC USII USIO RX TX ]
	localparam int R_TX    = 0; // drive uart tx
	localparam int R_RX    = 1; // pin feeds uart rx
	localparam int R_USIO  = 2; // drive usi out
	localparam int R_USII  = 3; // pin feeds usi in
	localparam int R_USOC  = 4; // usi out, open collector
	localparam int R_TXOC  = 5; // uart tx, open collector
	localparam int R_LVL   = 6; // level for plain drive
	localparam int R_LVLEN = 7; // enable plain drive

	// extra byte
	localparam int EXTRA_AVRPROG = 0; // avr programming enable

	// target io pins, zero based index below
	localparam int NUM_TIO        = 4;
	localparam int TIO_OC_PIN     = 2; // pin 3 has the open collector modes
	localparam int TIO_TXONLY_PIN = 3; // pin 4 has only tx and level drive

endpackage

/* cw_reg_file.sv */
`timescale 1ns/1ps

module cw_reg_file #(
	parameter int ADDR_W = 6
) (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic [ADDR_W-1:0]                                 reg_addr_i,
	input  logic [cw_reg_pkg::BYTECNT_W-1:0]                  reg_bytecnt_i,
	input  logic [cw_reg_pkg::DATA_W-1:0]                     reg_wdata_i,
	input  logic                                              reg_write_i,
	input  logic                                              reg_read_i,
	output logic [cw_reg_pkg::DATA_W-1:0]                     reg_rdata_o,
	output logic                                              reg_rvalid_o,
	output logic [cw_reg_pkg::DATA_W-1:0]                     trigsrc_o,
	output logic [cw_reg_pkg::DATA_W-1:0]                     trigmod_o,
	output logic [cw_reg_pkg::GPIO_BYTES*cw_reg_pkg::DATA_W-1:0] gpio_route_o,
	output logic                                              avrprog_en_o
);

	localparam int SEL_W = $clog2(cw_reg_pkg::IOROUTE_BYTES); // storage slot index

	logic [cw_reg_pkg::DATA_W-1:0] trigsrc_q;
	logic [cw_reg_pkg::DATA_W-1:0] trigmod_q;
	logic [cw_reg_pkg::IOROUTE_BYTES-1:0][cw_reg_pkg::DATA_W-1:0] route_q; // gpio1..4, extra

	logic                          rd_known; // address decodes to a register
	logic [cw_reg_pkg::DATA_W-1:0] rd_data;  // byte picked for readback
	logic                          is_gpio;  // byte count hits a gpio byte
	logic                          is_extra; // byte count hits the extra byte

	assign is_gpio  = reg_bytecnt_i < cw_reg_pkg::GPIO_BYTES;
	assign is_extra = reg_bytecnt_i == cw_reg_pkg::IOROUTE_EXTRA_IDX;

	// write decode, unknown addresses and dropped bytes fall through
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= cw_reg_pkg::TRIGSRC_RST;
			trigmod_q <= cw_reg_pkg::TRIGMOD_RST;
			route_q   <= cw_reg_pkg::IOROUTE_RST;
		end else if (reg_write_i) begin
			case (reg_addr_i)
				cw_reg_pkg::ADDR_TRIGSRC: trigsrc_q <= reg_wdata_i;
				cw_reg_pkg::ADDR_TRIGMOD: trigmod_q <= reg_wdata_i;
				cw_reg_pkg::ADDR_IOROUTE: begin
					if (is_gpio)
						route_q[reg_bytecnt_i[SEL_W-1:0]] <= reg_wdata_i;
					else if (is_extra)
						route_q[cw_reg_pkg::GPIO_BYTES] <= reg_wdata_i; // extra lives after gpio
				end
				default: ;
			endcase
		end
	end

	// readback mux
	always_comb begin
		rd_known = 1'b1;
		rd_data  = '0;
		case (reg_addr_i)
			cw_reg_pkg::ADDR_TRIGSRC: rd_data = trigsrc_q;
			cw_reg_pkg::ADDR_TRIGMOD: rd_data = trigmod_q;
			cw_reg_pkg::ADDR_IOROUTE: begin
				if (is_gpio)
					rd_data = route_q[reg_bytecnt_i[SEL_W-1:0]];
				else if (is_extra)
					rd_data = route_q[cw_reg_pkg::GPIO_BYTES];
				// glitch and reserved bytes stay zero
			end
			default: rd_known = 1'b0;
		endcase
	end

	// one valid cycle per read cycle, data forced to zero otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_rvalid_o <= 1'b0;
			reg_rdata_o  <= '0;
		end else begin
			reg_rvalid_o <= reg_read_i && rd_known;
			reg_rdata_o  <= (reg_read_i && rd_known) ? rd_data : '0;
		end
	end

	assign trigsrc_o    = trigsrc_q;
	assign trigmod_o    = trigmod_q;
	assign gpio_route_o = route_q[cw_reg_pkg::GPIO_BYTES-1:0];
	assign avrprog_en_o = route_q[cw_reg_pkg::GPIO_BYTES][cw_route_pkg::EXTRA_AVRPROG];

	// host issues one strobe per cycle
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(reg_read_i && reg_write_i));

	// routing accesses stay inside the eight byte window
	a_route_span: assert property (@(posedge clk) disable iff (reset)
		((reg_read_i || reg_write_i) && reg_addr_i == cw_reg_pkg::ADDR_IOROUTE)
		|-> (reg_bytecnt_i < cw_reg_pkg::IOROUTE_SPAN));

endmodule

/* cw_trigger_route.sv */
`timescale 1ns/1ps

module cw_trigger_route (
	input  logic [cw_reg_pkg::DATA_W-1:0]    trigsrc_i,
	input  logic [cw_reg_pkg::DATA_W-1:0]    trigmod_i,
	input  logic                             trigger_fpa_i,
	input  logic                             trigger_fpb_i,
	input  logic [cw_route_pkg::NUM_TIO-1:0] trigger_io_i,
	input  logic                             trigger_advio_i,
	input  logic                             trigger_anapattern_i,
	output logic                             trigger_o,
	output logic                             trigger_ext_o,
	output logic                             trigger_fpa_oe_o,
	output logic                             trigger_fpb_oe_o
);

	logic [cw_route_pkg::TRIG_LINES-1:0]    lines;     // all external trigger inputs
	logic [cw_route_pkg::TRIG_LINES-1:0]    mask;      // per line enable
	logic [cw_route_pkg::COMB_W-1:0]        comb_mode;
	logic [cw_route_pkg::TRIGMOD_SEL_W-1:0] mod_sel;
	logic                                   trig_or;
	logic                                   trig_and;
	logic                                   trig_ext;
	logic                                   trig_sel;

	// gather lines in register bit order
	assign lines[cw_route_pkg::TRIGSRC_FPA] = trigger_fpa_i;
	assign lines[cw_route_pkg::TRIGSRC_FPB] = trigger_fpb_i;
	assign lines[cw_route_pkg::TRIGSRC_IO_LSB +: cw_route_pkg::NUM_TIO] = trigger_io_i;

	assign mask      = trigsrc_i[cw_route_pkg::TRIG_LINES-1:0];
	assign comb_mode = trigsrc_i[cw_route_pkg::TRIGSRC_MODE_LSB +: cw_route_pkg::COMB_W];
	assign mod_sel   = trigmod_i[cw_route_pkg::TRIGMOD_SEL_W-1:0];

	assign trig_or  = |(lines & mask);  // nothing enabled gives 0
	assign trig_and = &(lines | ~mask); // disabled lines count as 1

	always_comb begin
		case (comb_mode)
			cw_route_pkg::COMB_OR:  trig_ext = trig_or;
			cw_route_pkg::COMB_AND: trig_ext = trig_and;
			default:                trig_ext = 1'b0; // codes 2 and 3 never fire
		endcase
	end

	// trigger module select
	always_comb begin
		case (mod_sel)
			cw_route_pkg::TRIGMOD_EDGE:  trig_sel = trig_ext;
			cw_route_pkg::TRIGMOD_ADVIO: trig_sel = trigger_advio_i;
			cw_route_pkg::TRIGMOD_ANA:   trig_sel = trigger_anapattern_i;
			default:                     trig_sel = 1'b0;
		endcase
	end

	assign trigger_o     = trig_sel;
	assign trigger_ext_o = trig_ext; // combined lines, before module select

	// front panel pins carry trigger_o when their enable bit is set
	assign trigger_fpa_oe_o = trigmod_i[cw_route_pkg::TRIGMOD_FPA_OE];
	assign trigger_fpb_oe_o = trigmod_i[cw_route_pkg::TRIGMOD_FPB_OE];

endmodule

/* cw_io_route.sv */
`timescale 1ns/1ps

module cw_io_route (
	input  logic [cw_reg_pkg::GPIO_BYTES*cw_reg_pkg::DATA_W-1:0] gpio_route_i,
	input  logic                                                 avrprog_en_i,
	input  logic                                                 uart_tx_i,
	input  logic                                                 usi_out_i,
	input  logic [cw_route_pkg::NUM_TIO-1:0]                     targetio_i,
	output logic [cw_route_pkg::NUM_TIO-1:0]                     targetio_o,
	output logic [cw_route_pkg::NUM_TIO-1:0]                     targetio_oe_o,
	output logic                                                 uart_rx_o,
	output logic                                                 usi_in_o,
	output logic                                                 avrprog_o
);

	// output drive, first match wins per pin
	always_comb begin : drive
		logic [cw_reg_pkg::DATA_W-1:0] cfg; // routing byte of the current pin
		for (int i = 0; i < cw_route_pkg::NUM_TIO; i++) begin
			cfg = gpio_route_i[i*cw_reg_pkg::DATA_W +: cw_reg_pkg::DATA_W];
			targetio_o[i]    = 1'b0;
			targetio_oe_o[i] = 1'b0; // high-z unless something claims the pin
			if (cfg[cw_route_pkg::R_TX]) begin
				targetio_oe_o[i] = 1'b1;
				targetio_o[i]    = uart_tx_i;
			end else if (cfg[cw_route_pkg::R_USIO] && i != cw_route_pkg::TIO_TXONLY_PIN) begin
				targetio_oe_o[i] = 1'b1;
				targetio_o[i]    = usi_out_i;
			end else if (cfg[cw_route_pkg::R_USOC] && i == cw_route_pkg::TIO_OC_PIN) begin
				targetio_oe_o[i] = ~usi_out_i; // pull low only, release on 1
			end else if (cfg[cw_route_pkg::R_TXOC] && i == cw_route_pkg::TIO_OC_PIN) begin
				targetio_oe_o[i] = ~uart_tx_i;
			end else if (cfg[cw_route_pkg::R_LVLEN]) begin
				targetio_oe_o[i] = 1'b1;
				targetio_o[i]    = cfg[cw_route_pkg::R_LVL]; // static level
			end
		end
	end

	// receive paths, lowest numbered pin wins
	// walk from the top so lower pins overwrite higher ones
	always_comb begin : receive
		uart_rx_o = 1'b1; // idle high when no pin is selected
		usi_in_o  = 1'b1;
		for (int i = cw_route_pkg::NUM_TIO - 1; i >= 0; i--) begin
			if (gpio_route_i[i*cw_reg_pkg::DATA_W + cw_route_pkg::R_RX])
				uart_rx_o = targetio_i[i];
			if (gpio_route_i[i*cw_reg_pkg::DATA_W + cw_route_pkg::R_USII] &&
			    i != cw_route_pkg::TIO_TXONLY_PIN)
				usi_in_o = targetio_i[i]; // pin 4 has no usi input
		end
	end

	assign avrprog_o = avrprog_en_i; // connects the programmer to the target

endmodule

/* cw_sys_top.sv */
`timescale 1ns/1ps

module cw_sys_top #(
	parameter int ADDR_W = 6
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [ADDR_W-1:0]               reg_addr_i,
	input  logic [cw_reg_pkg::BYTECNT_W-1:0] reg_bytecnt_i,
	input  logic [cw_reg_pkg::DATA_W-1:0]   reg_wdata_i,
	input  logic                            reg_write_i,
	input  logic                            reg_read_i,
	output logic [cw_reg_pkg::DATA_W-1:0]   reg_rdata_o,
	output logic                            reg_rvalid_o,
	input  logic                            trigger_fpa_i,
	input  logic                            trigger_fpb_i,
	input  logic [cw_reg_pkg::GPIO_BYTES-1:0] trigger_io_i,
	input  logic                            trigger_advio_i,
	input  logic                            trigger_anapattern_i,
	output logic                            trigger_o,
	output logic                            trigger_ext_o,
	output logic                            trigger_fpa_oe_o,
	output logic                            trigger_fpb_oe_o,
	input  logic                            uart_tx_i,
	input  logic                            usi_out_i,
	input  logic [cw_reg_pkg::GPIO_BYTES-1:0] targetio_i,
	output logic [cw_reg_pkg::GPIO_BYTES-1:0] targetio_o,
	output logic [cw_reg_pkg::GPIO_BYTES-1:0] targetio_oe_o,
	output logic                            uart_rx_o,
	output logic                            usi_in_o,
	output logic                            avrprog_o
);

	logic [cw_reg_pkg::DATA_W-1:0]                        trigsrc;
	logic [cw_reg_pkg::DATA_W-1:0]                        trigmod;
	logic [cw_reg_pkg::GPIO_BYTES*cw_reg_pkg::DATA_W-1:0] gpio_route; // one byte per pin
	logic                                                 avrprog_en;

	cw_reg_file #(.ADDR_W(ADDR_W)) u_reg_file (
		.clk(clk), .reset(reset),
		.reg_addr_i(reg_addr_i), .reg_bytecnt_i(reg_bytecnt_i), .reg_wdata_i(reg_wdata_i),
		.reg_write_i(reg_write_i), .reg_read_i(reg_read_i),
		.reg_rdata_o(reg_rdata_o), .reg_rvalid_o(reg_rvalid_o),
		.trigsrc_o(trigsrc), .trigmod_o(trigmod),
		.gpio_route_o(gpio_route), .avrprog_en_o(avrprog_en)
	);

	cw_trigger_route u_trigger_route (
		.trigsrc_i(trigsrc), .trigmod_i(trigmod),
		.trigger_fpa_i(trigger_fpa_i), .trigger_fpb_i(trigger_fpb_i),
		.trigger_io_i(trigger_io_i), .trigger_advio_i(trigger_advio_i),
		.trigger_anapattern_i(trigger_anapattern_i),
		.trigger_o(trigger_o), .trigger_ext_o(trigger_ext_o),
		.trigger_fpa_oe_o(trigger_fpa_oe_o), .trigger_fpb_oe_o(trigger_fpb_oe_o)
	);

	cw_io_route u_io_route (
		.gpio_route_i(gpio_route), .avrprog_en_i(avrprog_en),
		.uart_tx_i(uart_tx_i), .usi_out_i(usi_out_i),
		.targetio_i(targetio_i), .targetio_o(targetio_o), .targetio_oe_o(targetio_oe_o),
		.uart_rx_o(uart_rx_o), .usi_in_o(usi_in_o), .avrprog_o(avrprog_o)
	);

endmodule

/* tb_cw_sys.sv */
`timescale 1ns/1ps

module tb_cw_sys;

	localparam int ADDR_W    = 6;
	localparam int SEED      = 59020;
	localparam int RESET_CYC = 8;
	localparam int LINE_CYC  = 20;  // cycle budget per golden line
	localparam int RAND_ITER = 20;
	localparam int RAND_STEP = 33;  // 10 writes, 10 two-cycle reads, 3 checks
	localparam int RAND_CYC  = RAND_ITER * RAND_STEP;

	logic              clk;
	logic              reset;
	logic [ADDR_W-1:0] reg_addr;
	logic [15:0]       reg_bytecnt;
	logic [7:0]        reg_wdata;
	logic              reg_write;
	logic              reg_read;
	wire  [7:0]        reg_rdata;
	wire               reg_rvalid;
	logic [7:0]        tin;  // fpa fpb io4..io1 advio ana
	logic [5:0]        iin;  // uart tx, usi out, target io 4..1
	wire  [3:0]        trig; // trigger_o, ext, fpa oe, fpb oe
	wire  [10:0]       tio;  // pin out 4..1, pin oe 4..1, rx, usi in, avrprog

	int    fd;
	int    cycles = 0;
	int    limit = RESET_CYC + RAND_CYC;
	int    n_lines;
	string line;

	cw_sys_top #(.ADDR_W(ADDR_W)) u_dut (
		.clk(clk), .reset(reset),
		.reg_addr_i(reg_addr), .reg_bytecnt_i(reg_bytecnt), .reg_wdata_i(reg_wdata),
		.reg_write_i(reg_write), .reg_read_i(reg_read),
		.reg_rdata_o(reg_rdata), .reg_rvalid_o(reg_rvalid),
		.trigger_fpa_i(tin[7]), .trigger_fpb_i(tin[6]), .trigger_io_i(tin[5:2]),
		.trigger_advio_i(tin[1]), .trigger_anapattern_i(tin[0]),
		.trigger_o(trig[3]), .trigger_ext_o(trig[2]),
		.trigger_fpa_oe_o(trig[1]), .trigger_fpb_oe_o(trig[0]),
		.uart_tx_i(iin[5]), .usi_out_i(iin[4]), .targetio_i(iin[3:0]),
		.targetio_o(tio[10:7]), .targetio_oe_o(tio[6:3]),
		.uart_rx_o(tio[2]), .usi_in_o(tio[1]), .avrprog_o(tio[0])
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, the run did not finish within %0d cycles", limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %0h actual %0h", name, exp, act);
			abort_run();
		end
	endtask

	// expected trigger outputs from the mask, combine and select rules
	function automatic logic [3:0] trig_model(logic [7:0] src, logic [7:0] md, logic [7:0] t);
		logic [5:0] lines;
		logic       any_on; // some enabled line is high
		logic       all_on; // no enabled line is low
		logic       ext;
		logic       sel;
		lines  = {t[5:2], t[6], t[7]}; // fpa at bit 0 as in the register
		any_on = 1'b0;
		all_on = 1'b1;
		for (int k = 0; k < 6; k++) begin
			if (src[k] && lines[k])
				any_on = 1'b1;
			if (src[k] && !lines[k])
				all_on = 1'b0;
		end
		case (src[7:6])
			2'd0:    ext = any_on;
			2'd1:    ext = all_on; // stays 1 with nothing enabled
			default: ext = 1'b0;
		endcase
		case (md[2:0])
			3'd0:    sel = ext;
			3'd1:    sel = t[1];
			3'd2:    sel = t[0];
			default: sel = 1'b0;
		endcase
		return {sel, ext, md[3], md[4]};
	endfunction

	// reference pin drive and receive selection
	function automatic logic [10:0] io_model(logic [31:0] gp, logic avr, logic [5:0] i);
		logic [3:0] o;
		logic [3:0] oe;
		logic [7:0] c;
		logic       rx;
		logic       usi;
		logic       rx_hit;  // a lower pin already feeds rx
		logic       usi_hit;
		rx      = 1'b1;
		usi     = 1'b1;
		rx_hit  = 1'b0;
		usi_hit = 1'b0;
		for (int p = 0; p < 4; p++) begin // first selected pin from pin 1 upward
			c = gp[p*8 +: 8];
			{oe[p], o[p]} = 2'b00;
			if (c[0])
				{oe[p], o[p]} = {1'b1, i[5]};
			else if (c[2] && p != 3)
				{oe[p], o[p]} = {1'b1, i[4]};
			else if (c[4] && p == 2)
				oe[p] = ~i[4]; // open collector pulls low only
			else if (c[5] && p == 2)
				oe[p] = ~i[5];
			else if (c[7])
				{oe[p], o[p]} = {1'b1, c[6]};
			if (c[1] && !rx_hit) begin
				rx     = i[p];
				rx_hit = 1'b1;
			end
			if (c[3] && p != 3 && !usi_hit) begin
				usi     = i[p];
				usi_hit = 1'b1;
			end
		end
		return {o, oe, rx, usi, avr};
	endfunction

	// bus tasks start and end on a falling edge
	task automatic bus_write(int addr, int cnt, int data);
		reg_addr    = addr;
		reg_bytecnt = cnt;
		reg_wdata   = data;
		reg_write   = 1'b1;
		@(negedge clk);
		reg_write = 1'b0;
	endtask

	task automatic read_expect(int addr, int cnt, int data, int valid);
		string tag;
		tag         = $sformatf("read a%0d b%0d", addr, cnt);
		reg_addr    = addr;
		reg_bytecnt = cnt;
		reg_read    = 1'b1;
		@(negedge clk); // response sits in the cycle after the read edge
		reg_read = 1'b0;
		check_eq({tag, " valid"}, valid, reg_rvalid);
		check_eq({tag, " data"}, data, reg_rdata);
		@(negedge clk); // strobe gone so valid and data fall back to zero
		check_eq({tag, " idle valid"}, 0, reg_rvalid);
		check_eq({tag, " idle data"}, 0, reg_rdata);
	endtask

	task automatic apply_check(string name, logic [7:0] t, logic [5:0] i,
	                           logic [3:0] etrig, logic [10:0] eio);
		tin = t;
		iin = i;
		@(negedge clk);
		check_eq({name, " trigger"}, etrig, trig);
		check_eq({name, " io"}, eio, tio);
	endtask

	task automatic replay_golden();
		string       op;
		int          a;
		int          b;
		int          d;
		int          v;
		int          n_chk;
		logic [7:0]  t;
		logic [5:0]  i;
		logic [3:0]  et;
		logic [10:0] ei;
		n_chk = 0;
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op[0] == "#") begin
				void'($fgets(line, fd)); // skip the rest of a comment
			end else if (op == "W") begin
				void'($fscanf(fd, "%d %d %h", a, b, d));
				bus_write(a, b, d);
			end else if (op == "R") begin
				void'($fscanf(fd, "%d %d %h %d", a, b, d, v));
				read_expect(a, b, d, v);
			end else if (op == "C") begin
				void'($fscanf(fd, "%b %b %b %b", t, i, et, ei));
				n_chk++;
				apply_check($sformatf("golden check %0d", n_chk), t, i, et, ei);
			end else begin
				$display("golden file holds an unknown operation %s", op);
				abort_run();
			end
		end
	endtask

	// random register setups with readback and three random input vectors each
	task automatic random_phase();
		logic [7:0]  src;
		logic [7:0]  md;
		logic [31:0] gp;
		logic [7:0]  extra;
		logic [7:0]  t;
		logic [5:0]  i;
		for (int n = 0; n < RAND_ITER; n++) begin
			src   = $urandom;
			md    = $urandom;
			gp    = $urandom;
			extra = $urandom;
			bus_write(39, 0, src);
			bus_write(40, 0, md);
			for (int b = 0; b < 4; b++)
				bus_write(55, b, gp[b*8 +: 8]);
			bus_write(55, 5, extra);
			bus_write(55, 4, $urandom); // dropped and reserved bytes keep nothing
			bus_write(55, 6, $urandom);
			bus_write(55, 7, $urandom);
			read_expect(39, 0, src, 1);
			read_expect(40, 0, md, 1);
			for (int b = 0; b < 4; b++)
				read_expect(55, b, gp[b*8 +: 8], 1);
			read_expect(55, 5, extra, 1);
			read_expect(55, 4, 0, 1);
			read_expect(55, 6, 0, 1);
			read_expect(55, 7, 0, 1);
			repeat (3) begin
				t = $urandom;
				i = $urandom;
				apply_check($sformatf("random %0d", n), t, i,
				            trig_model(src, md, t), io_model(gp, extra[0], i));
			end
		end
	endtask

	initial begin
		reset       = 1'b1;
		reg_addr    = '0;
		reg_bytecnt = '0;
		reg_wdata   = '0;
		reg_write   = 1'b0;
		reg_read    = 1'b0;
		tin         = '0;
		iin         = '0;
		void'($urandom(SEED));
		n_lines = 0;
		fd = $fopen("cw_sys_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file cw_sys_golden.txt");
			abort_run();
		end else begin
			while ($fgets(line, fd) != 0)
				n_lines++;
			$fclose(fd);
			limit = RESET_CYC + LINE_CYC * n_lines + RAND_CYC;
			fd = $fopen("cw_sys_golden.txt", "r");
			repeat (RESET_CYC) @(negedge clk);
			reset = 1'b0;
			replay_golden();
			random_phase();
			$fclose(fd);
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* cw_sys_golden.txt */
# W addr cnt data, R addr cnt data valid (addr and cnt decimal, data hex)
# C tin{fpa fpb io4-1 adv ana} iin{tx usi tio4-1} trig{o ext oea oeb} io{o4-1 oe4-1 rx usi avr}
R 39 0 01 1
R 40 0 00 1
R 55 0 01 1
R 55 1 02 1
R 55 5 00 1
C 10000000 100000 1100 00010001010
# unknown address, then register writes
W 10 0 ff
R 10 0 00 0
R 39 0 01 1
W 39 0 3c
R 39 0 3c 1
W 40 0 18
R 40 0 18 1
W 55 0 02
W 55 1 0c
W 55 2 10
W 55 3 c2
W 55 5 01
W 55 4 aa
R 55 4 00 1
R 55 2 10 1
R 55 5 01 1
C 11000011 101010 0011 10001110011
C 00010000 010101 1111 10101010101
# and combine, module select, combine code 2
W 39 0 43
W 40 0 00
C 11000000 010101 1100 10101010101
C 10111100 010101 0000 10101010101
W 40 0 01
C 00000010 010101 1000 10101010101
W 40 0 02
C 00000001 010101 1000 10101010101
W 40 0 05
C 11000011 010101 0100 10101010101
W 39 0 bf
C 11111100 010101 0000 10101010101
# pin 3 open collector tx, pin 4 tx over usi
W 55 2 20
W 55 0 00
W 55 1 80
W 55 3 0d
W 55 5 00
C 00000000 001111 0000 00001110110
C 00000000 100000 0000 10001010110
# receive paths
W 55 1 08
W 55 2 0a
W 55 3 02
C 00000000 000110 0000 00000000110
C 00000000 001010 0000 00000000010

/* list.f */
cw_reg_pkg.sv
cw_route_pkg.sv
cw_reg_file.sv
cw_trigger_route.sv
cw_io_route.sv
cw_sys_top.sv
tb_cw_sys.sv

/* Bender.yml */
package:
  name: cw_sys

sources:
  - cw_reg_pkg.sv
  - cw_route_pkg.sv
  - cw_reg_file.sv
  - cw_trigger_route.sv
  - cw_io_route.sv
  - cw_sys_top.sv
  - target: simulation
    files:
      - tb_cw_sys.sv
